// File: common/zorro_pkg.sv
// zorro card package: bus types, cycle states, autoconfig table and card constants
package zorro_pkg;

	// ----------------------------------------------------------------------
	// bus and register types
	// ----------------------------------------------------------------------
	// latched byte address
	typedef logic [31:0] zaddr_t;
	// data word, logical order D31..D0
	typedef logic [31:0] zdata_t;
	// multiplexed lanes AD31:8
	typedef logic [23:0] zlane_hi_t;
	// DS3..DS0, low active, bit 3 strobes D31:24
	typedef logic [3:0] zbyte_en_n_t;
	// autoconfig register index, A8:2
	typedef logic [6:0] cfg_index_t;
	typedef logic [3:0] cfg_nibble_t;
	// assigned base, A31:16
	typedef logic [15:0] card_base_t;
	// card memory word index, A9:2
	typedef logic [7:0] mem_index_t;

	// bus cycle states
	typedef enum logic [2:0] {
		IDLE,
		MATCH,
		DATA,
		MEM_REQ,
		MEM_DONE,
		CFG_WRITE,
		DTACK
	} zorro_state_t;

	// ----------------------------------------------------------------------
	// address decode and autoconfig
	// ----------------------------------------------------------------------
	localparam logic [15:0] CFG_SPACE_HI = 16'hFF00;
	// A31:26 compared against the base
	localparam int CARD_MATCH_BITS = 6;
	// offset 44, base address write
	localparam cfg_index_t CFG_BASE_INDEX = 7'h11;
	// offset 4C, shut up
	localparam cfg_index_t CFG_SHUTUP_INDEX = 7'h13;

	// table entries in index order 0..7
	localparam cfg_nibble_t ER_TYPE = 4'hA;
	localparam cfg_nibble_t PRODUCT = 4'h1;
	localparam cfg_nibble_t FLAGS = 4'h3;
	localparam cfg_nibble_t MFR_HI = 4'h0;
	localparam cfg_nibble_t MFR_LO = 4'h7;
	localparam cfg_nibble_t SERIAL = 4'h1;
	localparam cfg_nibble_t SIZE = 4'h0;
	localparam cfg_nibble_t RESERVED = 4'h0;
	localparam cfg_nibble_t [7:0] CFG_ROM = {
		RESERVED, SIZE, SERIAL, MFR_LO, MFR_HI, FLAGS, PRODUCT, ER_TYPE
	};
	// bit set means the nibble reads back inverted, er_type is plain
	localparam logic [7:0] CFG_ROM_INVERT = 8'hFE;

	// stands in for dram latency
	localparam logic [1:0] MEM_WAIT_CYCLES = 2'd2;

endpackage

// File: zorro/zorro_bus_capture.sv
// zorro bus capture: strobe sampling, address latch, hit decode, write data, slave_n
`timescale 1ns/1ps

module zorro_bus_capture (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   fcs_n_i,
	input  logic                   doe_i,
	input  logic                   read_i,
	input  logic [1:0]             fc_i,
	input  zorro_pkg::zlane_hi_t   ad_i,
	input  logic [5:0]             a_i,
	input  logic [7:0]             sd_i,
	input  zorro_pkg::zbyte_en_n_t ds_n_i,
	input  logic                   cfgin_n_i,
	input  logic                   cfg_open_i,
	input  logic                   configured_i,
	input  zorro_pkg::card_base_t  card_base_i,
	output zorro_pkg::zaddr_t      addr_o,
	output logic                   cfg_hit_o,
	output logic                   card_hit_o,
	output logic                   cycle_active_o,
	output logic                   doe_o,
	output zorro_pkg::zbyte_en_n_t ds_n_o,
	output zorro_pkg::zdata_t      wdata_o,
	output logic                   slave_n_o
);
	import zorro_pkg::*;

	logic        fcs_n_q;
	logic        fcs_fall;
	logic        fc_valid;
	logic        cfg_dec;
	logic        card_dec;
	logic        doe_meta_q;
	zbyte_en_n_t ds_n_meta_q;
	logic        ds_active_q;
	logic        ds_start;

	// ----------------------------------------------------------------------
	// address phase decode
	// ----------------------------------------------------------------------
	assign fcs_fall = fcs_n_q & ~fcs_n_i;
	// FC 01 or 10 only, user/supervisor data
	assign fc_valid = fc_i[1] ^ fc_i[0];
	// ad_i[23:8] carries A31:16
	assign cfg_dec = fc_valid & cfg_open_i & ~cfgin_n_i & (ad_i[23:8] == CFG_SPACE_HI);
	assign card_dec = fc_valid & configured_i &
		(ad_i[23 -: CARD_MATCH_BITS] == card_base_i[15 -: CARD_MATCH_BITS]);
	assign cycle_active_o = ~fcs_n_q;

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			fcs_n_q <= 1'b1;
			cfg_hit_o <= 1'b0;
			card_hit_o <= 1'b0;
			slave_n_o <= 1'b1;
		end else begin
			fcs_n_q <= fcs_n_i;
			if (fcs_n_i) begin
				// cycle over, drop everything
				cfg_hit_o <= 1'b0;
				card_hit_o <= 1'b0;
				slave_n_o <= 1'b1;
			end else begin
				if (fcs_fall) begin
					cfg_hit_o <= cfg_dec;
					card_hit_o <= card_dec;
				end
				// one clock behind the hits
				slave_n_o <= ~(cfg_hit_o | card_hit_o);
			end
		end
	end

	// AD lanes go away right after fcs falls
	always_ff @(posedge clk) begin
		if (fcs_fall)
			addr_o <= {ad_i, a_i, 2'b00};
	end

	// ----------------------------------------------------------------------
	// data phase sync and write data
	// ----------------------------------------------------------------------
	assign ds_start = ~(&ds_n_o) & ~ds_active_q;

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			doe_meta_q <= 1'b0;
			doe_o <= 1'b0;
			ds_n_meta_q <= '1;
			ds_n_o <= '1;
			ds_active_q <= 1'b0;
		end else begin
			doe_meta_q <= doe_i;
			doe_o <= doe_meta_q;
			ds_n_meta_q <= ds_n_i;
			ds_n_o <= ds_n_meta_q;
			ds_active_q <= ~(&ds_n_o);
		end
	end

	// unswizzle: AD31:24 = D31:24, SD = D23:16, AD23:8 = D15:0
	always_ff @(posedge clk) begin
		if (ds_start && !read_i)
			wdata_o <= {ad_i[23:16], sd_i, ad_i[15:0]};
	end

endmodule

// File: zorro/zorro_cycle_fsm.sv
// zorro cycle state machine: match, data phase, config or memory access, DTACK
`timescale 1ns/1ps

module zorro_cycle_fsm (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   cycle_active_i,
	input  logic                   cfg_hit_i,
	input  logic                   card_hit_i,
	input  logic                   read_i,
	input  logic                   doe_i,
	input  zorro_pkg::zbyte_en_n_t ds_n_i,
	input  zorro_pkg::zaddr_t      addr_i,
	output logic                   cfg_wr_o,
	output zorro_pkg::cfg_index_t  cfg_index_o,
	output logic                   rd_load_cfg_o,
	output logic                   rd_load_mem_o,
	output logic                   mem_req_o,
	output logic                   mem_we_o,
	output zorro_pkg::mem_index_t  mem_index_o,
	output zorro_pkg::zbyte_en_n_t mem_be_n_o,
	input  logic                   mem_ack_i,
	output logic                   dtack_n_o
);
	import zorro_pkg::*;

	zorro_state_t state_q;
	zorro_state_t state_d;

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (cycle_active_i && (cfg_hit_i || card_hit_i))
					state_d = MATCH;
			end
			MATCH: begin
				if (!cycle_active_i)
					state_d = IDLE;
				else if (doe_i)
					state_d = DATA;
			end
			DATA: begin
				// master gave up before data time
				if (!cycle_active_i)
					state_d = IDLE;
				else if (read_i)
					state_d = cfg_hit_i ? DTACK : MEM_REQ;
				else if (!(&ds_n_i))
					state_d = cfg_hit_i ? CFG_WRITE : MEM_REQ;
			end
			MEM_REQ: begin
				// no abort here, handshake must finish
				if (mem_ack_i)
					state_d = MEM_DONE;
			end
			MEM_DONE: begin
				// req is low, wait for ack to follow
				if (!mem_ack_i)
					state_d = cycle_active_i ? DTACK : IDLE;
			end
			CFG_WRITE: begin
				state_d = cycle_active_i ? DTACK : IDLE;
			end
			DTACK: begin
				// held until fcs is seen high
				if (!cycle_active_i)
					state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// strobes and direction frozen when leaving DATA
	always_ff @(posedge clk) begin
		if (state_q == DATA) begin
			mem_be_n_o <= ds_n_i;
			mem_we_o <= ~read_i;
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign cfg_index_o = addr_i[8:2];
	// 1 KB alias
	assign mem_index_o = addr_i[9:2];
	assign mem_req_o = (state_q == MEM_REQ);
	// single clock write pulse
	assign cfg_wr_o = (state_q == CFG_WRITE);
	assign rd_load_cfg_o = (state_q == DATA) & cycle_active_i & read_i & cfg_hit_i;
	// read word valid together with ack
	assign rd_load_mem_o = (state_q == MEM_REQ) & mem_ack_i & ~mem_we_o;
	assign dtack_n_o = (state_q != DTACK);

endmodule

// File: zorro/zorro_data_drive.sv
// zorro read data register, lane swizzle and data output enable
`timescale 1ns/1ps

module zorro_data_drive (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   rd_load_cfg_i,
	input  logic                   rd_load_mem_i,
	input  zorro_pkg::cfg_nibble_t cfg_nibble_i,
	input  zorro_pkg::zdata_t      mem_rdata_i,
	input  logic                   slave_n_i,
	input  logic                   doe_i,
	input  logic                   read_i,
	output zorro_pkg::zlane_hi_t   ad_o,
	output logic [7:0]             sd_o,
	output logic                   data_oe_o
);
	import zorro_pkg::*;

	zdata_t rd_q;

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			rd_q <= '1;
		else if (rd_load_cfg_i)
			// config nibble sits in D31:28, rest reads high
			rd_q <= {cfg_nibble_i, 28'hFFF_FFFF};
		else if (rd_load_mem_i)
			rd_q <= mem_rdata_i;
	end

	// D31:24 on AD31:24, D15:0 on AD23:8
	assign ad_o = {rd_q[31:24], rd_q[15:0]};
	// D23:16 on SD7:0
	assign sd_o = rd_q[23:16];
	assign data_oe_o = ~slave_n_i & doe_i & read_i;

endmodule

// File: autoconfig/autoconfig_regs.sv
// autoconfig nibble table, base register, shut-up flag and cfgout chain
`timescale 1ns/1ps

module autoconfig_regs (
	input  logic                   clk,
	input  logic                   nIORST,
	input  zorro_pkg::cfg_index_t  cfg_index_i,
	input  logic                   cfg_wr_i,
	input  zorro_pkg::zdata_t      wdata_i,
	output zorro_pkg::cfg_nibble_t cfg_nibble_o,
	output logic                   cfg_open_o,
	output logic                   configured_o,
	output zorro_pkg::card_base_t  card_base_o,
	output logic                   cfgout_n_o
);
	import zorro_pkg::*;

	cfg_nibble_t rom_nibble;
	logic        shutup_q;

	// ----------------------------------------------------------------------
	// table lookup
	// ----------------------------------------------------------------------
	assign rom_nibble = CFG_ROM[cfg_index_i[2:0]];

	always_comb begin
		// unused registers read as F
		if (|cfg_index_i[6:3])
			cfg_nibble_o = 4'hF;
		else if (CFG_ROM_INVERT[cfg_index_i[2:0]])
			cfg_nibble_o = ~rom_nibble;
		else
			cfg_nibble_o = rom_nibble;
	end

	// ----------------------------------------------------------------------
	// config writes
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			card_base_o <= '0;
			configured_o <= 1'b0;
			shutup_q <= 1'b0;
		end else if (cfg_wr_i) begin
			if (cfg_index_i == CFG_BASE_INDEX) begin
				// base from the high data word
				card_base_o <= wdata_i[31:16];
				configured_o <= 1'b1;
			end
			if (cfg_index_i == CFG_SHUTUP_INDEX)
				shutup_q <= 1'b1;
		end
	end

	// still answering config space
	assign cfg_open_o = ~configured_o & ~shutup_q;
	// enable the next slot once done
	assign cfgout_n_o = ~(configured_o | shutup_q);

endmodule

// File: design/card_memory.sv
// card memory: 256 words, byte strobed writes, four-phase req/ack with a fixed wait
`timescale 1ns/1ps

module card_memory (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   mem_req_i,
	input  logic                   mem_we_i,
	input  zorro_pkg::mem_index_t  mem_index_i,
	input  zorro_pkg::zbyte_en_n_t mem_be_n_i,
	input  zorro_pkg::zdata_t      mem_wdata_i,
	output zorro_pkg::zdata_t      mem_rdata_o,
	output logic                   mem_ack_o
);
	import zorro_pkg::*;

	zdata_t     mem_q [256];
	logic [1:0] wait_q;
	logic       access;

	// wait done, ack not yet given
	assign access = mem_req_i & ~mem_ack_o & (wait_q == MEM_WAIT_CYCLES);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			wait_q <= '0;
			mem_ack_o <= 1'b0;
		end else if (!mem_req_i) begin
			// req gone, release ack
			wait_q <= '0;
			mem_ack_o <= 1'b0;
		end else if (access) begin
			wait_q <= '0;
			mem_ack_o <= 1'b1;
		end else if (!mem_ack_o) begin
			wait_q <= wait_q + 2'd1;
		end
	end

	// writes by byte strobe, reads full word
	always_ff @(posedge clk) begin
		if (access) begin
			if (mem_we_i) begin
				for (int b = 0; b < 4; b++) begin
					if (!mem_be_n_i[b])
						mem_q[mem_index_i][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
				end
			end else begin
				mem_rdata_o <= mem_q[mem_index_i];
			end
		end
	end

endmodule

// File: design/zorro_card_top.sv
// zorro card top: bus capture, cycle control, autoconfig, card memory and data drive
`timescale 1ns/1ps

module zorro_card_top (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   fcs_n_i,
	input  logic                   doe_i,
	input  logic                   read_i,
	input  logic [1:0]             fc_i,
	input  zorro_pkg::zlane_hi_t   ad_i,
	input  logic [5:0]             a_i,
	input  logic [7:0]             sd_i,
	input  zorro_pkg::zbyte_en_n_t ds_n_i,
	input  logic                   cfgin_n_i,
	output logic                   slave_n_o,
	output logic                   dtack_n_o,
	output logic                   cfgout_n_o,
	output zorro_pkg::zlane_hi_t   ad_o,
	output logic [7:0]             sd_o,
	output logic                   data_oe_o
);
	import zorro_pkg::*;

	// capture side
	zaddr_t      addr;
	logic        cfg_hit, card_hit, cycle_active, doe_s;
	zbyte_en_n_t ds_n_s;
	zdata_t      wdata;
	// autoconfig
	logic        cfg_open, configured, cfg_wr;
	card_base_t  card_base;
	cfg_index_t  cfg_index;
	cfg_nibble_t cfg_nibble;
	// read data loads
	logic        rd_load_cfg, rd_load_mem;
	// memory link
	logic        mem_req, mem_we, mem_ack;
	mem_index_t  mem_index;
	zbyte_en_n_t mem_be_n;
	zdata_t      mem_rdata;

	zorro_bus_capture u_capture (
		.clk (clk), .nIORST (nIORST), .fcs_n_i (fcs_n_i), .doe_i (doe_i),
		.read_i (read_i), .fc_i (fc_i), .ad_i (ad_i), .a_i (a_i), .sd_i (sd_i),
		.ds_n_i (ds_n_i), .cfgin_n_i (cfgin_n_i), .cfg_open_i (cfg_open),
		.configured_i (configured), .card_base_i (card_base), .addr_o (addr),
		.cfg_hit_o (cfg_hit), .card_hit_o (card_hit), .cycle_active_o (cycle_active),
		.doe_o (doe_s), .ds_n_o (ds_n_s), .wdata_o (wdata), .slave_n_o (slave_n_o)
	);

	zorro_cycle_fsm u_fsm (
		.clk (clk), .nIORST (nIORST), .cycle_active_i (cycle_active),
		.cfg_hit_i (cfg_hit), .card_hit_i (card_hit), .read_i (read_i),
		.doe_i (doe_s), .ds_n_i (ds_n_s), .addr_i (addr), .cfg_wr_o (cfg_wr),
		.cfg_index_o (cfg_index), .rd_load_cfg_o (rd_load_cfg),
		.rd_load_mem_o (rd_load_mem), .mem_req_o (mem_req), .mem_we_o (mem_we),
		.mem_index_o (mem_index), .mem_be_n_o (mem_be_n), .mem_ack_i (mem_ack),
		.dtack_n_o (dtack_n_o)
	);

	autoconfig_regs u_autoconfig (
		.clk (clk), .nIORST (nIORST), .cfg_index_i (cfg_index), .cfg_wr_i (cfg_wr),
		.wdata_i (wdata), .cfg_nibble_o (cfg_nibble), .cfg_open_o (cfg_open),
		.configured_o (configured), .card_base_o (card_base), .cfgout_n_o (cfgout_n_o)
	);

	card_memory u_memory (
		.clk (clk), .nIORST (nIORST), .mem_req_i (mem_req), .mem_we_i (mem_we),
		.mem_index_i (mem_index), .mem_be_n_i (mem_be_n), .mem_wdata_i (wdata),
		.mem_rdata_o (mem_rdata), .mem_ack_o (mem_ack)
	);

	// raw DOE here, lanes release as soon as the master drops it
	zorro_data_drive u_drive (
		.clk (clk), .nIORST (nIORST), .rd_load_cfg_i (rd_load_cfg),
		.rd_load_mem_i (rd_load_mem), .cfg_nibble_i (cfg_nibble),
		.mem_rdata_i (mem_rdata), .slave_n_i (slave_n_o), .doe_i (doe_i),
		.read_i (read_i), .ad_o (ad_o), .sd_o (sd_o), .data_oe_o (data_oe_o)
	);

endmodule

// File: tests/tb_zorro_card.sv
// zorro card testbench: LCG stimulus, reference model, bus cycle tasks and checks
`timescale 1ns/1ps

module tb_zorro_card;
	import zorro_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int BUS_CYCLES = 300;
	localparam int CLOCKS_PER_CYCLE = 40;
	localparam int TIMEOUT_CYCLES = BUS_CYCLES * CLOCKS_PER_CYCLE + 2 * RESET_CYCLES;
	// bounded waits inside one bus cycle
	localparam int SLAVE_WAIT = 6;
	localparam int DTACK_WAIT = 24;
	localparam int CARD_WRITES = 200;

	logic        clk = 1'b0;
	logic        nIORST;
	logic        fcs_n_i;
	logic        doe_i;
	logic        read_i;
	logic [1:0]  fc_i;
	zlane_hi_t   ad_i;
	logic [5:0]  a_i;
	logic [7:0]  sd_i;
	zbyte_en_n_t ds_n_i;
	logic        cfgin_n_i;
	logic        slave_n_o;
	logic        dtack_n_o;
	logic        cfgout_n_o;
	zlane_hi_t   ad_o;
	logic [7:0]  sd_o;
	logic        data_oe_o;

	// reference model state
	logic [31:0] rng_state;
	card_base_t  base_m;
	logic        configured_m;
	logic        shutup_m;
	zdata_t      mem_m [256];
	logic [3:0]  valid_m [256];
	mem_index_t  written_q [$];
	int          errors;
	int          checks;
	int          cycle_count;

	zorro_card_top dut0 (
		.clk (clk), .nIORST (nIORST), .fcs_n_i (fcs_n_i), .doe_i (doe_i),
		.read_i (read_i), .fc_i (fc_i), .ad_i (ad_i), .a_i (a_i), .sd_i (sd_i),
		.ds_n_i (ds_n_i), .cfgin_n_i (cfgin_n_i), .slave_n_o (slave_n_o),
		.dtack_n_o (dtack_n_o), .cfgout_n_o (cfgout_n_o), .ad_o (ad_o), .sd_o (sd_o),
		.data_oe_o (data_oe_o)
	);

	always #10 clk = ~clk;

	// ----------------------------------------------------------------------
	// random numbers and model rules
	// ----------------------------------------------------------------------
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		// fold high bits down since low LCG bits have short periods
		return rng_state ^ {16'h0000, rng_state[31:16]};
	endfunction

	// expected nibble from the table and its inversion rule
	function automatic cfg_nibble_t rom_expected(cfg_index_t idx);
		if (idx > 7'd7)
			return 4'hF;
		if (idx == 7'd0)
			return CFG_ROM[0];
		return ~CFG_ROM[idx[2:0]];
	endfunction

	function automatic logic responds(zaddr_t addr, logic [1:0] fc, logic cfgin_n);
		logic fc_ok;
		logic cfg_ok;
		logic card_ok;
		fc_ok = (fc == 2'b01) || (fc == 2'b10);
		cfg_ok = !configured_m && !shutup_m && !cfgin_n && (addr[31:16] == CFG_SPACE_HI);
		card_ok = configured_m && (addr[31:26] == base_m[15:10]);
		return fc_ok && (cfg_ok || card_ok);
	endfunction

	function automatic zaddr_t cfg_addr(cfg_index_t idx);
		return {CFG_SPACE_HI, 7'b0000000, idx, 2'b00};
	endfunction

	// random address inside the assigned window
	function automatic zaddr_t window_addr(mem_index_t idx);
		logic [31:0] r;
		r = next_random();
		return {base_m[15:10], r[25:10], idx, 2'b00};
	endfunction

	function automatic zdata_t byte_mask(logic [3:0] valid);
		return {{8{valid[3]}}, {8{valid[2]}}, {8{valid[1]}}, {8{valid[0]}}};
	endfunction

	function automatic void model_write(mem_index_t idx, zdata_t wdata, zbyte_en_n_t be_n);
		for (int b = 0; b < 4; b++) begin
			if (!be_n[b]) begin
				mem_m[idx][b*8 +: 8] = wdata[b*8 +: 8];
				valid_m[idx][b] = 1'b1;
			end
		end
	endfunction

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task automatic check_word(string name, zdata_t expected, zdata_t actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] time %0t: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] time %0t: %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_true(logic ok, string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	// ----------------------------------------------------------------------
	// bus side
	// ----------------------------------------------------------------------
	task automatic apply_reset();
		@(posedge clk);
		nIORST <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		nIORST <= 1'b1;
		@(negedge clk);
	endtask

	// one full bus cycle ending on a falling edge so outputs are settled
	task automatic bus_cycle(zaddr_t addr, logic [1:0] fc, logic cfgin_n, logic rd,
			zdata_t wdata, zbyte_en_n_t be_n, output zdata_t rdata, output logic answered);
		logic         expect_slave;
		int           waited;
		zorro_state_t st;
		expect_slave = responds(addr, fc, cfgin_n);
		rdata = '0;
		@(posedge clk);
		ad_i <= addr[31:8];
		a_i <= addr[7:2];
		fc_i <= fc;
		cfgin_n_i <= cfgin_n;
		read_i <= rd;
		@(posedge clk);
		fcs_n_i <= 1'b0;
		waited = 0;
		while (slave_n_o && waited < SLAVE_WAIT) begin
			@(negedge clk);
			waited++;
		end
		answered = !slave_n_o;
		if (expect_slave)
			check_true(answered, $sformatf("no slave_n response at address %h", addr));
		else
			check_true(!answered, $sformatf("unexpected slave_n response at address %h", addr));
		if (answered) begin
			@(posedge clk);
			doe_i <= 1'b1;
			// write lanes in bus order
			if (!rd) begin
				ad_i <= {wdata[31:24], wdata[15:0]};
				sd_i <= wdata[23:16];
				ds_n_i <= be_n;
			end
			waited = 0;
			while (dtack_n_o && waited < DTACK_WAIT) begin
				@(negedge clk);
				waited++;
			end
			if (dtack_n_o) begin
				st = dut0.u_fsm.state_q;
				check_true(1'b0, $sformatf("no dtack_n response at address %h, state %s",
					addr, st.name()));
			end else if (rd) begin
				check_bit("data_oe_o", 1'b1, data_oe_o);
				rdata = {ad_o[23:16], sd_o, ad_o[15:0]};
			end
		end
		@(posedge clk);
		fcs_n_i <= 1'b1;
		doe_i <= 1'b0;
		ds_n_i <= '1;
		waited = 0;
		while (!slave_n_o && waited < SLAVE_WAIT) begin
			@(negedge clk);
			waited++;
		end
		check_true(slave_n_o, "slave_n still asserted after fcs_n went high");
		@(negedge clk);
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		zdata_t      rdata;
		logic        answered;
		zaddr_t      addr;
		zdata_t      wdata;
		zbyte_en_n_t be_n;
		cfg_index_t  idx;
		mem_index_t  midx;
		logic [31:0] r;
		int          pick;
		rng_state = 32'h3e4ab552;
		errors = 0;
		checks = 0;
		base_m = '0;
		configured_m = 1'b0;
		shutup_m = 1'b0;
		for (int i = 0; i < 256; i++)
			valid_m[i] = 4'b0000;
		nIORST <= 1'b0;
		fcs_n_i <= 1'b1;
		doe_i <= 1'b0;
		read_i <= 1'b1;
		fc_i <= 2'b01;
		ad_i <= '0;
		a_i <= '0;
		sd_i <= '0;
		ds_n_i <= '1;
		cfgin_n_i <= 1'b0;
		apply_reset();

		// idle outputs after reset
		check_bit("slave_n_o", 1'b1, slave_n_o);
		check_bit("dtack_n_o", 1'b1, dtack_n_o);
		check_bit("cfgout_n_o", 1'b1, cfgout_n_o);
		check_bit("data_oe_o", 1'b0, data_oe_o);
		// base register resets to zero so probe that window
		bus_cycle(window_addr(8'h00), 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);

		// config table reads
		for (idx = 7'd0; idx < 7'd16; idx++) begin
			bus_cycle(cfg_addr(idx), 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);
			if (answered)
				check_word("config read data", {rom_expected(idx), 28'hFFF_FFFF}, rdata);
		end
		// chain input high and then invalid FC codes
		bus_cycle(cfg_addr(7'd0), 2'b01, 1'b1, 1'b1, '0, '1, rdata, answered);
		bus_cycle(cfg_addr(7'd0), 2'b00, 1'b0, 1'b1, '0, '1, rdata, answered);
		bus_cycle(cfg_addr(7'd0), 2'b11, 1'b0, 1'b1, '0, '1, rdata, answered);

		// base write moves the card into its window
		r = next_random();
		bus_cycle(cfg_addr(CFG_BASE_INDEX), 2'b10, 1'b0, 1'b0, {r[31:16], 16'h0000},
			4'b0000, rdata, answered);
		base_m = r[31:16];
		configured_m = 1'b1;
		check_bit("cfgout_n_o", 1'b0, cfgout_n_o);
		bus_cycle(cfg_addr(7'd0), 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);
		bus_cycle(window_addr(8'h00), 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);

		// random writes mixed with read backs and probes outside the window
		for (int n = 0; n < CARD_WRITES; n++) begin
			r = next_random();
			be_n = r[27:24];
			if (&be_n)
				be_n = 4'b0000;
			midx = r[15:8];
			wdata = next_random();
			bus_cycle(window_addr(midx), r[4] ? 2'b10 : 2'b01, 1'b0, 1'b0, wdata, be_n,
				rdata, answered);
			model_write(midx, wdata, be_n);
			written_q.push_back(midx);
			if (r[31:30] == 2'b00) begin
				pick = int'(r[23:16]) % written_q.size();
				midx = written_q[pick];
				bus_cycle(window_addr(midx), 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);
				if (answered)
					check_word("card read data", mem_m[midx] & byte_mask(valid_m[midx]),
						rdata & byte_mask(valid_m[midx]));
			end
			if (r[29:27] == 3'b000) begin
				addr = window_addr(r[23:16]);
				addr[31] = ~addr[31];
				bus_cycle(addr, 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);
			end
		end

		// second reset then shut up
		apply_reset();
		base_m = '0;
		configured_m = 1'b0;
		check_bit("cfgout_n_o", 1'b1, cfgout_n_o);
		bus_cycle(cfg_addr(CFG_SHUTUP_INDEX), 2'b01, 1'b0, 1'b0, '0, 4'b0000, rdata, answered);
		shutup_m = 1'b1;
		check_bit("cfgout_n_o", 1'b0, cfgout_n_o);
		bus_cycle(cfg_addr(7'd0), 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);
		bus_cycle(window_addr(8'h10), 2'b01, 1'b0, 1'b1, '0, '1, rdata, answered);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// run limit in clocks
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run still busy after %0d clocks", cycle_count);
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: project.f
common/zorro_pkg.sv
zorro/zorro_bus_capture.sv
zorro/zorro_cycle_fsm.sv
zorro/zorro_data_drive.sv
autoconfig/autoconfig_regs.sv
design/card_memory.sv
design/zorro_card_top.sv
tests/tb_zorro_card.sv

// File: run.sh
#!/bin/sh
# builds the zorro card testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_zorro_card -f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
out=$(./obj_dir/Vtb_zorro_card)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
